// File: Makefile
# Verilator build and run for the PE array testbench

VERILATOR ?= verilator
TOP       ?= tb_pe_array
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PATTERNS  ?= pe_patterns.txt

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM) $(PATTERNS)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf $(BUILD_DIR)

// File: coef_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module coef_arbiter (
   input  logic                          clk,
   input  logic                          rst,
   input  cpx_pkg::coef_req_t            req [cpx_pkg::NUM_PE],
   output logic [cpx_pkg::COEF_AW-1:0]   rom_addr,
   input  cpx_pkg::cpx_t                 rom_data,
   output logic [cpx_pkg::NUM_PE-1:0]    gnt,
   output cpx_pkg::cpx_t                 coef_data
);

   logic [cpx_pkg::NUM_PE-1:0]          want;   // live req, not already in flight
   logic [cpx_pkg::NUM_PE-1:0]          pend;   // grant pulses next cycle
   logic [$clog2(cpx_pkg::NUM_PE)-1:0]  last;   // pe served last
   logic [$clog2(cpx_pkg::NUM_PE)-1:0]  pick;
   logic                                pick_v;

   always_comb begin
      for (int i = 0; i < cpx_pkg::NUM_PE; i++)
         want[i] = req[i].req && !pend[i];
   end

   // round robin, search starts just after last
   always_comb begin
      int idx;
      pick_v = 1'b0;
      pick   = last;
      for (int k = 1; k <= cpx_pkg::NUM_PE; k++) begin
         idx = (int'(last) + k) % cpx_pkg::NUM_PE;
         if (!pick_v && want[idx]) begin
            pick_v = 1'b1;
            pick   = idx[$clog2(cpx_pkg::NUM_PE)-1:0];
         end
      end
   end

   assign rom_addr  = req[pick].idx;   // rom latches it this edge
   assign gnt       = pend;            // rom output lands with the pulse
   assign coef_data = rom_data;

   always_ff @(posedge clk) begin
      if (rst) begin
         last <= '1;   // pe0 first after reset
         pend <= '0;
      end else begin
         pend <= '0;
         if (pick_v) begin
            pend[pick] <= 1'b1;
            last       <= pick;
         end
      end
   end

endmodule

`default_nettype wire

// File: coef_rom.sv
`timescale 1ns/1ps
`default_nettype none

module coef_rom (
   input  logic                         clk,
   input  logic [cpx_pkg::COEF_AW-1:0]  addr,
   output cpx_pkg::cpx_t                data
);

   // e^(-j*2*pi*k/8) in Q1.14, 0.7071 -> 11585
   always_ff @(posedge clk) begin
      case (addr)
         3'd0:    data <= '{re:  16'sd16384, im:  16'sd0};
         3'd1:    data <= '{re:  16'sd11585, im: -16'sd11585};
         3'd2:    data <= '{re:  16'sd0,     im: -16'sd16384};   // -j
         3'd3:    data <= '{re: -16'sd11585, im: -16'sd11585};
         3'd4:    data <= '{re: -16'sd16384, im:  16'sd0};
         3'd5:    data <= '{re: -16'sd11585, im:  16'sd11585};
         3'd6:    data <= '{re:  16'sd0,     im:  16'sd16384};   // +j
         default: data <= '{re:  16'sd11585, im:  16'sd11585};
      endcase
   end

endmodule

`default_nettype wire

// File: complex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module complex_alu (
   input  logic                        clk,
   input  logic                        rst,
   input  cpx_pkg::alu_op_t            issue,
   output logic                        wb_v,
   output logic [cpx_pkg::MEM_AW-1:0]  wb_addr,
   output cpx_pkg::cpx_t               wb_data
);

   cpx_pkg::alu_op_t                       s1;
   logic                                   s2_v;
   cpx_pkg::opcode_e                       s2_op;
   logic [cpx_pkg::MEM_AW-1:0]             s2_dst;
   cpx_pkg::cpx_t                          s2_res;   // add/sub/mov result
   logic signed [2*cpx_pkg::DATA_W-1:0]    p_rr, p_ii, p_ri, p_ir;
   logic signed [2*cpx_pkg::DATA_W-1:0]    m_re, m_im;

   ////////////////////////////////////////////////////////////////////////////
   // stage 1, operand register
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      s1 <= issue;
      if (rst)
         s1.v <= 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // stage 2, sum / difference / partial products
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      s2_v   <= rst ? 1'b0 : s1.v;
      s2_op  <= s1.op;
      s2_dst <= s1.dst;
      p_rr   <= s1.a.re * s1.coef.re;   // full 32b products
      p_ii   <= s1.a.im * s1.coef.im;
      p_ri   <= s1.a.re * s1.coef.im;
      p_ir   <= s1.a.im * s1.coef.re;
      case (s1.op)
         cpx_pkg::OP_ADD: begin
            s2_res.re <= s1.a.re + s1.b.re;   // wraps at 16b
            s2_res.im <= s1.a.im + s1.b.im;
         end
         cpx_pkg::OP_SUB: begin
            s2_res.re <= s1.a.re - s1.b.re;
            s2_res.im <= s1.a.im - s1.b.im;
         end
         default:
            s2_res <= s1.a;   // mov
      endcase
   end

   // each term scaled before the add
   assign m_re = (p_rr >>> cpx_pkg::FRAC_W) - (p_ii >>> cpx_pkg::FRAC_W);
   assign m_im = (p_ri >>> cpx_pkg::FRAC_W) + (p_ir >>> cpx_pkg::FRAC_W);

   ////////////////////////////////////////////////////////////////////////////
   // stage 3, combine and wrap to DATA_W
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      wb_v    <= rst ? 1'b0 : s2_v;
      wb_addr <= s2_dst;
      if (s2_op == cpx_pkg::OP_MULC) begin
         wb_data.re <= m_re[cpx_pkg::DATA_W-1:0];
         wb_data.im <= m_im[cpx_pkg::DATA_W-1:0];
      end else begin
         wb_data <= s2_res;
      end
   end

endmodule

`default_nettype wire

// File: cpx_pkg.sv
`default_nettype none

package cpx_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // sizes
   ////////////////////////////////////////////////////////////////////////////
   localparam int DATA_W   = 16;   // one real or imag part
   localparam int NUM_PE   = 2;
   localparam int LOAD_NUM = 4;    // samples per block
   localparam int OUT_NUM  = 4;    // results per block
   localparam int MEM_AW   = 3;    // 8 complex words per pe
   localparam int PROG_LEN = 16;
   localparam int PC_W     = 4;
   localparam int COEF_AW  = 3;    // 8 twiddles
   localparam int ALU_LAT  = 3;    // issue to writeback
   localparam int FRAC_W   = 14;   // Q1.14 coefficients

   // one complex word, real part in the upper half
   typedef struct packed {
      logic signed [DATA_W-1:0] re;
      logic signed [DATA_W-1:0] im;
   } cpx_t;

   typedef enum logic [2:0] {
      OP_NOP,
      OP_ADD,    // dst = a + b
      OP_SUB,    // dst = a - b
      OP_MOV,    // dst = a
      OP_MULC,   // dst = a * twiddle[cidx]
      OP_END
   } opcode_e;

   typedef struct packed {
      opcode_e             op;
      logic [MEM_AW-1:0]   dst;
      logic [MEM_AW-1:0]   src_a;
      logic [MEM_AW-1:0]   src_b;
      logic [COEF_AW-1:0]  cidx;
   } inst_t;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOAD,
      ST_COMPUTE,
      ST_DRAIN,
      ST_OUTPUT
   } pe_state_e;

   // held level towards the arbiter
   typedef struct packed {
      logic                req;
      logic [COEF_AW-1:0]  idx;
   } coef_req_t;

   // one slot of the alu pipe
   typedef struct packed {
      logic                v;
      opcode_e             op;
      logic [MEM_AW-1:0]   dst;
      cpx_t                a;
      cpx_t                b;
      cpx_t                coef;
   } alu_op_t;

endpackage

`default_nettype wire

// File: data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
   input  logic                        clk,
   input  logic                        ld_v,
   input  logic [cpx_pkg::MEM_AW-1:0]  ld_addr,
   input  cpx_pkg::cpx_t               ld_data,
   input  logic                        wb_v,
   input  logic [cpx_pkg::MEM_AW-1:0]  wb_addr,
   input  cpx_pkg::cpx_t               wb_data,
   input  logic [cpx_pkg::MEM_AW-1:0]  ra_addr,
   input  logic [cpx_pkg::MEM_AW-1:0]  rb_addr,
   output cpx_pkg::cpx_t               ra_data,
   output cpx_pkg::cpx_t               rb_data
);

   cpx_pkg::cpx_t mem [2**cpx_pkg::MEM_AW];   // 0..3 samples, 4..7 temporaries

   // two write ports, writeback last so it wins on a clash
   always_ff @(posedge clk) begin
      if (ld_v)
         mem[ld_addr] <= ld_data;
      if (wb_v)
         mem[wb_addr] <= wb_data;
   end

   assign ra_data = mem[ra_addr];   // async read, operands seen at issue
   assign rb_data = mem[rb_addr];

endmodule

`default_nettype wire

// File: inst_rom.sv
`timescale 1ns/1ps
`default_nettype none

module inst_rom (
   input  logic                      clk,
   input  logic [cpx_pkg::PC_W-1:0]  pc,
   output cpx_pkg::inst_t            inst
);

   function automatic cpx_pkg::inst_t mk(cpx_pkg::opcode_e op,
                                         logic [cpx_pkg::MEM_AW-1:0] d,
                                         logic [cpx_pkg::MEM_AW-1:0] a,
                                         logic [cpx_pkg::MEM_AW-1:0] b,
                                         logic [cpx_pkg::COEF_AW-1:0] c);
      return '{op: op, dst: d, src_a: a, src_b: b, cidx: c};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // 4-point dft, x0..x3 in words 0..3, results back in place
   // consumers sit at least 4 slots after their producer
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      case (pc)
         4'd0:    inst <= mk(cpx_pkg::OP_ADD,  3'd4, 3'd0, 3'd2, 3'd0); // t4 = x0 + x2
         4'd1:    inst <= mk(cpx_pkg::OP_SUB,  3'd5, 3'd0, 3'd2, 3'd0); // t5 = x0 - x2
         4'd2:    inst <= mk(cpx_pkg::OP_ADD,  3'd6, 3'd1, 3'd3, 3'd0); // t6 = x1 + x3
         4'd3:    inst <= mk(cpx_pkg::OP_SUB,  3'd7, 3'd1, 3'd3, 3'd0); // t7 = x1 - x3
         4'd7:    inst <= mk(cpx_pkg::OP_MULC, 3'd7, 3'd7, 3'd0, 3'd2); // t7 *= -j
         4'd8:    inst <= mk(cpx_pkg::OP_ADD,  3'd0, 3'd4, 3'd6, 3'd0); // X0
         4'd9:    inst <= mk(cpx_pkg::OP_SUB,  3'd2, 3'd4, 3'd6, 3'd0); // X2
         4'd11:   inst <= mk(cpx_pkg::OP_ADD,  3'd1, 3'd5, 3'd7, 3'd0); // X1
         4'd12:   inst <= mk(cpx_pkg::OP_SUB,  3'd3, 3'd5, 3'd7, 3'd0); // X3
         4'd13:   inst <= mk(cpx_pkg::OP_END,  3'd0, 3'd0, 3'd0, 3'd0);
         default: inst <= mk(cpx_pkg::OP_NOP,  3'd0, 3'd0, 3'd0, 3'd0); // spacing
      endcase
   end

endmodule

`default_nettype wire

// File: pe.sv
`timescale 1ns/1ps
`default_nettype none

module pe (
   input  logic                clk,
   input  logic                rst,
   input  logic                in_v,
   input  cpx_pkg::cpx_t       in_data,
   output cpx_pkg::coef_req_t  coef_req,
   input  logic                coef_gnt,
   input  cpx_pkg::cpx_t       coef_data,
   output logic                out_v,
   output cpx_pkg::cpx_t       out_data,
   output logic                busy
);

   cpx_pkg::pe_state_e           state;
   logic [cpx_pkg::MEM_AW-1:0]   ld_cnt;    // next load address
   logic [cpx_pkg::MEM_AW-1:0]   out_cnt;   // next output address
   logic [1:0]                   drain_cnt;
   logic [cpx_pkg::PC_W-1:0]     pc;        // address of inst on rom output
   logic [cpx_pkg::PC_W-1:0]     pc_next;   // rom fetch address
   cpx_pkg::inst_t               inst;
   logic                         ld_v;
   logic                         advance;   // inst leaves this cycle
   logic                         prog_end;
   cpx_pkg::alu_op_t             issue;
   logic                         wb_v;
   logic [cpx_pkg::MEM_AW-1:0]   wb_addr;
   cpx_pkg::cpx_t                wb_data;
   logic [cpx_pkg::MEM_AW-1:0]   ra_addr;
   cpx_pkg::cpx_t                ra_data, rb_data;

   ////////////////////////////////////////////////////////////////////////////
   // fetch
   ////////////////////////////////////////////////////////////////////////////
   assign prog_end = inst.op == cpx_pkg::OP_END || pc == cpx_pkg::PROG_LEN - 1;
   assign advance  = state == cpx_pkg::ST_COMPUTE &&
                     (inst.op != cpx_pkg::OP_MULC || coef_gnt);   // mulc waits for gnt

   always_comb begin
      if (state != cpx_pkg::ST_COMPUTE)
         pc_next = '0;              // program starts at 0 on entry
      else if (advance && !prog_end)
         pc_next = pc + 1'b1;
      else
         pc_next = pc;              // stall holds rom output
   end

   inst_rom i_irom (
      .clk  (clk),
      .pc   (pc_next),
      .inst (inst)
   );

   // coefficient request, held until the gnt pulse
   assign coef_req.req = state == cpx_pkg::ST_COMPUTE && inst.op == cpx_pkg::OP_MULC;
   assign coef_req.idx = inst.cidx;

   ////////////////////////////////////////////////////////////////////////////
   // data memory and alu
   ////////////////////////////////////////////////////////////////////////////
   assign ld_v    = in_v && (state == cpx_pkg::ST_IDLE || state == cpx_pkg::ST_LOAD);
   assign ra_addr = state == cpx_pkg::ST_OUTPUT ? out_cnt : inst.src_a;

   data_mem i_dmem (
      .clk     (clk),
      .ld_v    (ld_v),
      .ld_addr (ld_cnt),
      .ld_data (in_data),
      .wb_v    (wb_v),
      .wb_addr (wb_addr),
      .wb_data (wb_data),
      .ra_addr (ra_addr),
      .rb_addr (inst.src_b),
      .ra_data (ra_data),
      .rb_data (rb_data)
   );

   always_comb begin
      issue.v    = advance && inst.op inside {cpx_pkg::OP_ADD, cpx_pkg::OP_SUB,
                                              cpx_pkg::OP_MOV, cpx_pkg::OP_MULC};
      issue.op   = inst.op;
      issue.dst  = inst.dst;
      issue.a    = ra_data;
      issue.b    = rb_data;
      issue.coef = coef_data;   // only meaningful in the gnt cycle
   end

   complex_alu i_alu (
      .clk     (clk),
      .rst     (rst),
      .issue   (issue),
      .wb_v    (wb_v),
      .wb_addr (wb_addr),
      .wb_data (wb_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= cpx_pkg::ST_IDLE;
         ld_cnt    <= '0;
         out_cnt   <= '0;
         drain_cnt <= '0;
         pc        <= '0;
      end else begin
         pc <= pc_next;
         if (ld_v)
            ld_cnt <= (ld_cnt == cpx_pkg::LOAD_NUM - 1) ? '0 : ld_cnt + 1'b1;
         case (state)
            cpx_pkg::ST_IDLE: begin
               if (in_v)
                  state <= cpx_pkg::ST_LOAD;   // word 0 written now
            end
            cpx_pkg::ST_LOAD: begin
               if (in_v && ld_cnt == cpx_pkg::LOAD_NUM - 1)
                  state <= cpx_pkg::ST_COMPUTE;
            end
            cpx_pkg::ST_COMPUTE: begin
               if (prog_end)
                  state <= cpx_pkg::ST_DRAIN;
            end
            cpx_pkg::ST_DRAIN: begin           // last writebacks land
               drain_cnt <= drain_cnt + 1'b1;
               if (drain_cnt == cpx_pkg::ALU_LAT - 1) begin
                  drain_cnt <= '0;
                  state     <= cpx_pkg::ST_OUTPUT;
               end
            end
            cpx_pkg::ST_OUTPUT: begin
               out_cnt <= out_cnt + 1'b1;
               if (out_cnt == cpx_pkg::OUT_NUM - 1) begin
                  out_cnt <= '0;
                  state   <= cpx_pkg::ST_IDLE;
               end
            end
            default:
               state <= cpx_pkg::ST_IDLE;      // recover
         endcase
      end
   end

   assign out_v    = state == cpx_pkg::ST_OUTPUT;
   assign out_data = ra_data;   // words 0..3 in order
   assign busy     = state != cpx_pkg::ST_IDLE;

endmodule

`default_nettype wire

// File: pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module pe_array (
   input  logic                        clk,
   input  logic                        rst,
   input  logic [cpx_pkg::NUM_PE-1:0]  in_v,
   input  cpx_pkg::cpx_t               in_data [cpx_pkg::NUM_PE],
   output logic [cpx_pkg::NUM_PE-1:0]  out_v,
   output cpx_pkg::cpx_t               out_data [cpx_pkg::NUM_PE],
   output logic [cpx_pkg::NUM_PE-1:0]  busy
);

   cpx_pkg::coef_req_t                 coef_req [cpx_pkg::NUM_PE];
   logic [cpx_pkg::NUM_PE-1:0]         coef_gnt;
   cpx_pkg::cpx_t                      coef_data;   // shared, valid with gnt
   logic [cpx_pkg::COEF_AW-1:0]        rom_addr;
   cpx_pkg::cpx_t                      rom_data;

   pe i_pe0 (
      .clk       (clk),
      .rst       (rst),
      .in_v      (in_v[0]),
      .in_data   (in_data[0]),
      .coef_req  (coef_req[0]),
      .coef_gnt  (coef_gnt[0]),
      .coef_data (coef_data),
      .out_v     (out_v[0]),
      .out_data  (out_data[0]),
      .busy      (busy[0])
   );

   pe i_pe1 (
      .clk       (clk),
      .rst       (rst),
      .in_v      (in_v[1]),
      .in_data   (in_data[1]),
      .coef_req  (coef_req[1]),
      .coef_gnt  (coef_gnt[1]),
      .coef_data (coef_data),
      .out_v     (out_v[1]),
      .out_data  (out_data[1]),
      .busy      (busy[1])
   );

   coef_arbiter i_arb (
      .clk       (clk),
      .rst       (rst),
      .req       (coef_req),
      .rom_addr  (rom_addr),
      .rom_data  (rom_data),
      .gnt       (coef_gnt),
      .coef_data (coef_data)
   );

   coef_rom i_crom (
      .clk  (clk),
      .addr (rom_addr),
      .data (rom_data)
   );

endmodule

`default_nettype wire

// File: pe_patterns.txt
# mask offset | pe0 x0..x3 X0..X3 | pe1 x0..x3 X0..X3, all hex, re in upper 16 bits
# mask bit n starts pe n, offset delays pe1 start in cycles, unused pe rows are zero
1 0 00010000 00020000 00030000 00040000 000a0000 fffe0002 fffe0000 fffefffe 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0064ffce ffec001e 00070008 fffffffe 0056fff2 007dffd9 0080ffba 003dffb3
1 0 7fff8000 7fff8000 0001ffff 00000000 ffffffff fffe0002 0001ffff fffe0000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
2 0 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 80007fff ffffffff 80000001 00050000 00047fff ffff8004 fffc8001 00017ff8
3 0 000a0014 001e0028 0032003c 00460050 00a000c8 ffb00000 ffd8ffd8 0000ffb0 6000a000 60001000 20003000 b0007000 90005000 e000c000 70005000 a0002000
3 0 00000001 00000000 00000000 00000000 00000001 00000001 00000001 00000001 0003fffc fffd0004 0003fffc fffd0004 00000000 00000000 000cfff0 00000000
3 0 80007fff ffffffff 80000001 00050000 00047fff ffff8004 fffc8001 00017ff8 7fff8000 7fff8000 0001ffff 00000000 ffffffff fffe0002 0001ffff fffe0000
3 3 0064ffce ffec001e 00070008 fffffffe 0056fff2 007dffd9 0080ffba 003dffb3 00010000 00020000 00030000 00040000 000a0000 fffe0002 fffe0000 fffefffe
3 7 6000a000 60001000 20003000 b0007000 90005000 e000c000 70005000 a0002000 000a0014 001e0028 0032003c 00460050 00a000c8 ffb00000 ffd8ffd8 0000ffb0
3 1 0003fffc fffd0004 0003fffc fffd0004 00000000 00000000 000cfff0 00000000 00000001 00000000 00000000 00000000 00000001 00000001 00000001 00000001
3 c 00010000 00020000 00030000 00040000 000a0000 fffe0002 fffe0000 fffefffe 80007fff ffffffff 80000001 00050000 00047fff ffff8004 fffc8001 00017ff8
3 0 0064ffce ffec001e 00070008 fffffffe 0056fff2 007dffd9 0080ffba 003dffb3 0064ffce ffec001e 00070008 fffffffe 0056fff2 007dffd9 0080ffba 003dffb3

// File: sources.f
cpx_pkg.sv
inst_rom.sv
data_mem.sv
complex_alu.sv
coef_rom.sv
coef_arbiter.sv
pe.sv
pe_array.sv
tb_pe_array.sv

// File: tb_pe_array.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pe_array;

   localparam int MAX_TESTS       = 64;
   localparam int CYCLES_PER_TEST = 200;   // watchdog budget per pattern line
   localparam int NUM_FIELDS      = 18;    // mask, offset, 2 x (4 in + 4 out)

   logic                        clk;
   logic                        rst;
   logic [cpx_pkg::NUM_PE-1:0]  in_v;
   cpx_pkg::cpx_t               in_data  [cpx_pkg::NUM_PE];
   logic [cpx_pkg::NUM_PE-1:0]  out_v;
   cpx_pkg::cpx_t               out_data [cpx_pkg::NUM_PE];
   logic [cpx_pkg::NUM_PE-1:0]  busy;

   // pattern table filled once before reset ends
   int             n_tests;
   logic           loaded;
   logic [1:0]     start_mask  [MAX_TESTS];
   int             start_off   [MAX_TESTS];   // pe1 delay in cycles
   cpx_pkg::cpx_t  samples     [MAX_TESTS][cpx_pkg::NUM_PE][cpx_pkg::LOAD_NUM];
   cpx_pkg::cpx_t  results_tab [MAX_TESTS][cpx_pkg::NUM_PE][cpx_pkg::OUT_NUM];

   cpx_pkg::cpx_t  exp0_q [$];   // outstanding results per pe
   cpx_pkg::cpx_t  exp1_q [$];
   int             run_len [cpx_pkg::NUM_PE];
   int             gap_tab [cpx_pkg::NUM_PE][cpx_pkg::LOAD_NUM];

   pe_array i_dut (
      .clk      (clk),
      .rst      (rst),
      .in_v     (in_v),
      .in_data  (in_data),
      .out_v    (out_v),
      .out_data (out_data),
      .busy     (busy)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;   // 125 MHz
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped on first error");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // pattern file
   ////////////////////////////////////////////////////////////////////////////
   task automatic load_patterns();
      int           fd;
      int           cnt;
      string        line;
      logic [31:0]  f [NUM_FIELDS];
      fd = $fopen("pe_patterns.txt", "r");
      assert (fd != 0) else abort_run("cannot open pe_patterns.txt for reading");
      n_tests = 0;
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 8 || line.substr(0, 0) == "#")
            continue;   // blank or column notes
         cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                       f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
         assert (cnt == NUM_FIELDS)
            else abort_run($sformatf("pattern line %0d has too few fields", n_tests + 1));
         assert (n_tests < MAX_TESTS) else abort_run("too many pattern lines");
         start_mask[n_tests] = f[0][1:0];
         start_off[n_tests]  = int'(f[1]);
         for (int p = 0; p < cpx_pkg::NUM_PE; p++) begin
            for (int i = 0; i < 4; i++) begin
               samples[n_tests][p][i]     = f[2 + 8*p + i];
               results_tab[n_tests][p][i] = f[6 + 8*p + i];
            end
         end
         n_tests++;
      end
      $fclose(fd);
      assert (n_tests > 0) else abort_run("no test lines found in pe_patterns.txt");
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////
   task automatic feed_block(input int p, input int t);
      for (int i = 0; i < cpx_pkg::LOAD_NUM; i++) begin
         repeat (gap_tab[p][i]) begin
            @(posedge clk);
            in_v[p] <= 1'b0;
         end
         @(posedge clk);
         in_v[p]    <= 1'b1;
         in_data[p] <= samples[t][p][i];
      end
      @(posedge clk);
      in_v[p] <= 1'b0;
      @(negedge clk);   // pe has just entered compute
      assert (busy[p])
         else abort_run($sformatf("FAIL busy[%0d] got %h expected %h", p, busy[p], 1'b1));
      repeat (2) begin           // stray strobes while the pe computes
         @(posedge clk);
         in_v[p]    <= 1'b1;
         in_data[p] <= $urandom;
      end
      @(posedge clk);
      in_v[p] <= 1'b0;
   endtask

   task automatic run_test(input int t);
      for (int i = 0; i < cpx_pkg::LOAD_NUM; i++) begin
         gap_tab[0][i] = $urandom % 3;
         // same gaps at offset 0 keeps both pes in lockstep, so they contend
         gap_tab[1][i] = (start_off[t] == 0) ? gap_tab[0][i] : $urandom % 3;
      end
      for (int i = 0; i < cpx_pkg::OUT_NUM; i++) begin
         if (start_mask[t][0])
            exp0_q.push_back(results_tab[t][0][i]);
         if (start_mask[t][1])
            exp1_q.push_back(results_tab[t][1][i]);
      end
      fork
         begin
            if (start_mask[t][0])
               feed_block(0, t);
         end
         begin
            if (start_mask[t][1]) begin
               repeat (start_off[t]) @(posedge clk);
               feed_block(1, t);
            end
         end
      join
      while (exp0_q.size() != 0 || exp1_q.size() != 0 || busy != '0)
         @(negedge clk);
      repeat (2) @(posedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // checking
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_idle();
      repeat (4) begin
         @(negedge clk);
         assert (out_v == '0)
            else abort_run($sformatf("FAIL out_v got %h expected %h", out_v, 2'b00));
         assert (busy == '0)
            else abort_run($sformatf("FAIL busy got %h expected %h", busy, 2'b00));
      end
   endtask

   task automatic collect(input int p, input logic v, input cpx_pkg::cpx_t got);
      cpx_pkg::cpx_t  want;
      int             pending;
      pending = (p == 0) ? exp0_q.size() : exp1_q.size();
      if (v) begin
         assert (pending > 0)
            else abort_run($sformatf("pe%0d raised out_v with no block outstanding", p));
         if (p == 0)
            want = exp0_q.pop_front();
         else
            want = exp1_q.pop_front();
         assert (got == want)
            else abort_run($sformatf("FAIL out_data[%0d] got %h expected %h", p, got, want));
         run_len[p]++;
      end else if (run_len[p] != 0) begin   // burst just ended
         assert (run_len[p] == cpx_pkg::OUT_NUM)
            else abort_run($sformatf("FAIL out_v[%0d] burst length got %h expected %h",
                                     p, run_len[p], cpx_pkg::OUT_NUM));
         run_len[p] = 0;
      end
   endtask

   always @(negedge clk) begin   // mid cycle with outputs settled
      if (!rst) begin
         collect(0, out_v[0], out_data[0]);
         collect(1, out_v[1], out_data[1]);
      end
   end

   initial begin : watchdog
      wait (loaded);
      repeat (n_tests * CYCLES_PER_TEST) @(posedge clk);
      $display("timeout, outputs never arrived within %0d cycles",
               n_tests * CYCLES_PER_TEST);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog expired");
   end

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      void'($urandom(32'h806f));
      rst        = 1'b1;
      in_v       = '0;
      in_data[0] = '0;
      in_data[1] = '0;
      run_len[0] = 0;
      run_len[1] = 0;
      loaded     = 1'b0;
      load_patterns();
      loaded = 1'b1;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      check_idle();   // nothing moves before the first sample
      for (int t = 0; t < n_tests; t++)
         run_test(t);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire
